// ==== verilog/exu_pkg.sv ====
package exu_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int XLEN   = 64;  // data / result width
  localparam int ADDR_W = 32;  // byte address width

  // ----------------------------------------------------------
  // issue encodings
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    INST_ALU   = 2'd0,  // add, done in the stage
    INST_LOAD  = 2'd1,
    INST_STORE = 2'd2
  } inst_type_t;

  // access size, bytes = 1 << size
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } mem_size_t;

  // ----------------------------------------------------------
  // axi response codes
  // ----------------------------------------------------------
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== verilog/exu_fsm.sv ====
module exu_fsm
  import exu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // issue side
  input  inst_type_t inst_type_i,
  input  logic       valid_pre_i,
  output logic       ready_pre_o,
  output logic       issue_o,      // instruction taken this cycle

  // write-back side
  output logic       valid_post_o,
  input  logic       ready_post_i,

  // axi handshakes
  input  logic       awready_i,
  output logic       awvalid_o,
  input  logic       wready_i,
  output logic       wvalid_o,
  input  logic       bvalid_i,
  output logic       bready_o,
  input  logic       arready_i,
  output logic       arvalid_o,
  input  logic       rvalid_i,
  output logic       rready_o
);

  localparam logic [2:0] S_IDLE     = 3'b000;
  localparam logic [2:0] S_WB_WAIT  = 3'b001;  // result held for write-back
  localparam logic [2:0] S_AR_WAIT  = 3'b010;
  localparam logic [2:0] S_R_WAIT   = 3'b011;
  localparam logic [2:0] S_AWW_WAIT = 3'b100;  // aw and w both outstanding
  localparam logic [2:0] S_AW_WAIT  = 3'b101;  // w done, aw still open
  localparam logic [2:0] S_W_WAIT   = 3'b110;  // aw done, w still open
  localparam logic [2:0] S_B_WAIT   = 3'b111;

  logic [2:0] state_q;
  logic [2:0] state_d;

  // ----------------------------------------------------------
  // outputs, decoded from state
  // ----------------------------------------------------------
  assign ready_pre_o  = (state_q == S_IDLE);
  assign issue_o      = valid_pre_i && ready_pre_o;

  assign valid_post_o = (state_q == S_WB_WAIT) ||
                        ((state_q == S_R_WAIT) && rvalid_i) ||
                        ((state_q == S_B_WAIT) && bvalid_i);

  assign arvalid_o = (state_q == S_AR_WAIT);
  assign rready_o  = (state_q == S_R_WAIT);

  assign awvalid_o = (state_q == S_AWW_WAIT) || (state_q == S_AW_WAIT);
  assign wvalid_o  = (state_q == S_AWW_WAIT) || (state_q == S_W_WAIT);
  assign bready_o  = (state_q == S_B_WAIT);

  // ----------------------------------------------------------
  // state register
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------
  // next state
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (valid_pre_i) begin
          case (inst_type_i)
            INST_LOAD:  state_d = S_AR_WAIT;
            INST_STORE: state_d = S_AWW_WAIT;
            default:    state_d = S_WB_WAIT;  // alu result ready next cycle
          endcase
        end
      end
      S_AR_WAIT: begin
        if (arready_i) state_d = S_R_WAIT;
      end
      S_R_WAIT: begin
        // r beat is taken regardless, lsu keeps the result
        if (rvalid_i) state_d = ready_post_i ? S_IDLE : S_WB_WAIT;
      end
      S_AWW_WAIT: begin
        if (awready_i && wready_i) begin
          state_d = S_B_WAIT;
        end else if (awready_i) begin
          state_d = S_W_WAIT;
        end else if (wready_i) begin
          state_d = S_AW_WAIT;
        end
      end
      S_AW_WAIT: begin
        if (awready_i) state_d = S_B_WAIT;
      end
      S_W_WAIT: begin
        if (wready_i) state_d = S_B_WAIT;
      end
      S_B_WAIT: begin
        if (bvalid_i) state_d = ready_post_i ? S_IDLE : S_WB_WAIT;
      end
      S_WB_WAIT: begin
        if (ready_post_i) state_d = S_IDLE;
      end
      default: state_d = S_IDLE;
    endcase
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  // one memory request in flight at a time
  a_ar_aw_excl: assert property (@(posedge clk) disable iff (!rst)
    !(arvalid_o && awvalid_o))
    else $error("arvalid and awvalid high together");

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst)
    arvalid_o && !arready_i |=> arvalid_o)
    else $error("arvalid dropped before arready");

endmodule

// ==== verilog/exu_lsu.sv ====
module exu_lsu
  import exu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  input  logic              issue_i,
  input  inst_type_t        inst_type_i,
  input  mem_size_t         size_i,
  input  logic              unsigned_i,
  input  logic [XLEN-1:0]   op_a_i,
  input  logic [XLEN-1:0]   op_b_i,

  input  logic              r_hs_i,       // r channel handshake
  input  logic [XLEN-1:0]   rdata_i,
  input  logic [1:0]        rresp_i,
  input  logic              b_hs_i,       // b channel handshake
  input  logic [1:0]        bresp_i,

  output logic [ADDR_W-1:0] addr_o,
  output logic [XLEN-1:0]   wdata_o,
  output logic [XLEN/8-1:0] wstrb_o,
  output logic [XLEN-1:0]   result_o,
  output logic              err_o
);

  inst_type_t        kind_q;
  logic              err_q;
  logic [ADDR_W-1:0] addr_q;
  mem_size_t         size_q;
  logic              uns_q;
  logic [XLEN-1:0]   data_q;   // alu sum or lane-placed store data
  logic [XLEN/8-1:0] strb_q;
  logic [XLEN-1:0]   res_q;    // held load/store result

  logic [2:0]        off_in;
  logic [XLEN/8-1:0] mask_in;
  logic [XLEN-1:0]   shifted;
  logic [XLEN-1:0]   load_val;

  // ----------------------------------------------------------
  // issue side lane placement
  // ----------------------------------------------------------
  assign off_in = op_a_i[2:0];

  always_comb begin
    case (size_i)
      SIZE_B:  mask_in = 8'h01;
      SIZE_H:  mask_in = 8'h03;
      SIZE_W:  mask_in = 8'h0f;
      default: mask_in = 8'hff;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      kind_q <= INST_ALU;
      err_q  <= 1'b0;
    end else if (issue_i) begin
      kind_q <= inst_type_i;
      err_q  <= 1'b0;
    end else if (r_hs_i) begin
      err_q  <= (rresp_i != RESP_OKAY);
    end else if (b_hs_i) begin
      err_q  <= (bresp_i != RESP_OKAY);
    end
  end

  always_ff @(posedge clk) begin
    if (issue_i) begin
      addr_q <= op_a_i[ADDR_W-1:0];  // op_a is the address for memory ops
      size_q <= size_i;
      uns_q  <= unsigned_i;
      data_q <= (inst_type_i == INST_ALU) ? op_a_i + op_b_i
                                          : op_b_i << {off_in, 3'b000};
      strb_q <= (inst_type_i == INST_STORE) ? mask_in << off_in : '0;
    end
    if (r_hs_i) begin
      res_q <= load_val;
    end else if (b_hs_i) begin
      res_q <= '0;  // stores return zero
    end
  end

  // ----------------------------------------------------------
  // load alignment and extension
  // ----------------------------------------------------------
  assign shifted = rdata_i >> {addr_q[2:0], 3'b000};

  always_comb begin
    case (size_q)
      SIZE_B:  load_val = uns_q ? {{(XLEN-8){1'b0}}, shifted[7:0]}
                                : {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      SIZE_H:  load_val = uns_q ? {{(XLEN-16){1'b0}}, shifted[15:0]}
                                : {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      SIZE_W:  load_val = uns_q ? {{(XLEN-32){1'b0}}, shifted[31:0]}
                                : {{(XLEN-32){shifted[31]}}, shifted[31:0]};
      default: load_val = shifted;
    endcase
  end

  assign addr_o  = addr_q;
  assign wdata_o = data_q;
  assign wstrb_o = strb_q;

  // live value in the handshake cycle, held value after
  assign result_o = (kind_q == INST_ALU) ? data_q   :
                    r_hs_i               ? load_val :
                    b_hs_i               ? '0       : res_q;
  assign err_o    = r_hs_i ? (rresp_i != RESP_OKAY) :
                    b_hs_i ? (bresp_i != RESP_OKAY) : err_q;

endmodule

// ==== verilog/axi_dmem.sv ====
module axi_dmem
  import exu_pkg::*;
#(
  parameter int MEM_WORDS = 256  // depth in 64-bit words, power of two
) (
  input  logic              clk,
  input  logic              rst,

  // write address
  input  logic              awvalid_i,
  output logic              awready_o,
  input  logic [ADDR_W-1:0] awaddr_i,
  // write data
  input  logic              wvalid_i,
  output logic              wready_o,
  input  logic [XLEN-1:0]   wdata_i,
  input  logic [XLEN/8-1:0] wstrb_i,
  // write response
  output logic              bvalid_o,
  input  logic              bready_i,
  output logic [1:0]        bresp_o,
  // read address
  input  logic              arvalid_i,
  output logic              arready_o,
  input  logic [ADDR_W-1:0] araddr_i,
  // read data
  output logic              rvalid_o,
  input  logic              rready_i,
  output logic [XLEN-1:0]   rdata_o,
  output logic [1:0]        rresp_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [XLEN-1:0]   mem [MEM_WORDS];

  logic              aw_pend;
  logic              w_pend;
  logic [ADDR_W-1:0] aw_addr_q;
  logic [XLEN-1:0]   w_data_q;
  logic [XLEN/8-1:0] w_strb_q;

  logic              aw_hs, w_hs, ar_hs;
  logic              wr_fire;
  logic [ADDR_W-1:0] wr_addr;
  logic [XLEN-1:0]   wr_data;
  logic [XLEN/8-1:0] wr_strb;
  logic              wr_ok, rd_ok;

  // ----------------------------------------------------------
  // channel acceptance
  // ----------------------------------------------------------
  assign awready_o = !aw_pend;
  assign wready_o  = !w_pend;
  assign arready_o = !rvalid_o;  // one read outstanding

  assign aw_hs = awvalid_i && awready_o;
  assign w_hs  = wvalid_i && wready_o;
  assign ar_hs = arvalid_i && arready_o;

  // either the latched beat or the one arriving now
  assign wr_addr = aw_pend ? aw_addr_q : awaddr_i;
  assign wr_data = w_pend  ? w_data_q  : wdata_i;
  assign wr_strb = w_pend  ? w_strb_q  : wstrb_i;

  // write completes once both halves are here and b slot is free
  assign wr_fire = (aw_pend || aw_hs) && (w_pend || w_hs) && (!bvalid_o || bready_i);

  assign wr_ok = (wr_addr[ADDR_W-1:IDX_W+3] == '0);
  assign rd_ok = (araddr_i[ADDR_W-1:IDX_W+3] == '0);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      aw_pend  <= 1'b0;
      w_pend   <= 1'b0;
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      if (wr_fire) begin
        aw_pend <= 1'b0;
        w_pend  <= 1'b0;
      end else begin
        if (aw_hs) aw_pend <= 1'b1;
        if (w_hs)  w_pend  <= 1'b1;
      end
      if (wr_fire) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (ar_hs) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // storage and payload
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (aw_hs) aw_addr_q <= awaddr_i;
    if (w_hs) begin
      w_data_q <= wdata_i;
      w_strb_q <= wstrb_i;
    end
    if (wr_fire) begin
      bresp_o <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      if (wr_ok) begin
        for (int b = 0; b < XLEN/8; b++) begin
          if (wr_strb[b]) mem[wr_addr[IDX_W+2:3]][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
    if (ar_hs) begin
      rdata_o <= rd_ok ? mem[araddr_i[IDX_W+2:3]] : '0;  // zero on error
      rresp_o <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  a_b_after_write: assert property (@(posedge clk) disable iff (!rst)
    $rose(bvalid_o) |-> $past((aw_pend || awvalid_i) && (w_pend || wvalid_i)))
    else $error("bvalid without a completed write");

  a_r_stable: assert property (@(posedge clk) disable iff (!rst)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
    else $error("read data changed while stalled");

endmodule

// ==== verilog/exu_top.sv ====
module exu_top
  import exu_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic            clk,
  input  logic            rst,

  // issue
  input  logic            valid_pre_i,
  output logic            ready_pre_o,
  input  inst_type_t      inst_type_i,
  input  mem_size_t       size_i,
  input  logic            unsigned_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,

  // write-back
  output logic            valid_post_o,
  input  logic            ready_post_i,
  output logic [XLEN-1:0] result_o,
  output logic            err_o
);

  logic              issue;
  logic              awvalid, awready, wvalid, wready, bvalid, bready;
  logic              arvalid, arready, rvalid, rready;
  logic              r_hs, b_hs;
  logic [ADDR_W-1:0] addr;
  logic [XLEN-1:0]   wdata, rdata;
  logic [XLEN/8-1:0] wstrb;
  logic [1:0]        rresp, bresp;

  assign r_hs = rvalid & rready;
  assign b_hs = bvalid & bready;

  exu_fsm u_fsm (
    .clk          (clk),
    .rst          (rst),
    .inst_type_i  (inst_type_i),
    .valid_pre_i  (valid_pre_i),
    .ready_pre_o  (ready_pre_o),
    .issue_o      (issue),
    .valid_post_o (valid_post_o),
    .ready_post_i (ready_post_i),
    .awready_i    (awready),
    .awvalid_o    (awvalid),
    .wready_i     (wready),
    .wvalid_o     (wvalid),
    .bvalid_i     (bvalid),
    .bready_o     (bready),
    .arready_i    (arready),
    .arvalid_o    (arvalid),
    .rvalid_i     (rvalid),
    .rready_o     (rready)
  );

  exu_lsu u_lsu (
    .clk         (clk),
    .rst         (rst),
    .issue_i     (issue),
    .inst_type_i (inst_type_i),
    .size_i      (size_i),
    .unsigned_i  (unsigned_i),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .r_hs_i      (r_hs),
    .rdata_i     (rdata),
    .rresp_i     (rresp),
    .b_hs_i      (b_hs),
    .bresp_i     (bresp),
    .addr_o      (addr),
    .wdata_o     (wdata),
    .wstrb_o     (wstrb),
    .result_o    (result_o),
    .err_o       (err_o)
  );

  // same address register feeds both aw and ar
  axi_dmem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_dmem (
    .clk       (clk),
    .rst       (rst),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .awaddr_i  (addr),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .bresp_o   (bresp),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (addr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rresp_o   (rresp)
  );

endmodule

// ==== tb/tb_exu_top.sv ====
module tb_exu_top
  import exu_pkg::*;
();

  localparam int MEM_WORDS = 256;
  localparam int IDX_W     = $clog2(MEM_WORDS);
  localparam int N_ALU     = 40;  // alu_add
  localparam int N_PAIRS   = 20;  // store/load pairs
  localparam int N_MIXED   = 60;  // back_pressure traffic after the prefill
  // sub_word is 4 stores and 30 loads, out_of_range 5, prefill 8
  localparam int N_INST    = N_ALU + 2 * N_PAIRS + 34 + 5 + 8 + N_MIXED;
  localparam int LIMIT     = 10 * N_INST * 12;  // 4 cycles each, plus stalls and issue gap

  logic            clk = 1'b0;
  logic            rst;
  logic            valid_pre_i;
  logic            ready_pre_o;
  inst_type_t      inst_type_i;
  mem_size_t       size_i;
  logic            unsigned_i;
  logic [XLEN-1:0] op_a_i;
  logic [XLEN-1:0] op_b_i;
  logic            valid_post_o;
  logic            ready_post_i;
  logic [XLEN-1:0] result_o;
  logic            err_o;

  logic [31:0]     lfsr;
  logic [XLEN-1:0] ref_mem [MEM_WORDS];  // mirror of the dmem contents
  logic [XLEN-1:0] exp_res_q [$];
  logic            exp_err_q [$];
  logic            head_valid;
  logic [XLEN-1:0] head_res;
  logic            head_err;
  logic            xfer_next;            // write-back transfer on the coming edge
  logic            bp_en;
  logic [1:0]      stretch;
  string           cur_test;
  int              fail_cnt = 0;
  int              xfer_cnt = 0;
  int              cycles   = 0;

  always #10 clk = ~clk;

  exu_top #(
    .MEM_WORDS (MEM_WORDS)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .valid_pre_i  (valid_pre_i),
    .ready_pre_o  (ready_pre_o),
    .inst_type_i  (inst_type_i),
    .size_i       (size_i),
    .unsigned_i   (unsigned_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .valid_post_o (valid_post_o),
    .ready_post_i (ready_post_i),
    .result_o     (result_o),
    .err_o        (err_o)
  );

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------
  // galois lfsr, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hd000_0001 : lfsr >> 1;
    end
    return v;
  endfunction

  function automatic logic in_range(input logic [ADDR_W-1:0] a);
    return a < MEM_WORDS * 8;
  endfunction

  task automatic ref_store(input logic [ADDR_W-1:0] a, input logic [XLEN-1:0] d,
                           input mem_size_t sz);
    int lane;
    for (int i = 0; i < (1 << sz); i++) begin
      lane = a[2:0] + i;
      if (lane < 8) ref_mem[a[IDX_W+2:3]][8*lane +: 8] = d[8*i +: 8];  // lanes past 7 dropped
    end
  endtask

  function automatic logic [XLEN-1:0] ref_load(input logic [ADDR_W-1:0] a,
                                               input mem_size_t sz, input logic uns);
    logic [XLEN-1:0] v;
    logic [XLEN-1:0] word;
    int              n;
    int              lane;
    n    = 1 << sz;
    word = ref_mem[a[IDX_W+2:3]];
    v    = '0;
    for (int i = 0; i < n; i++) begin
      lane = a[2:0] + i;
      if (lane < 8) v[8*i +: 8] = word[8*lane +: 8];
    end
    if (!uns && v[8*n-1]) begin
      for (int i = 8*n; i < XLEN; i++) v[i] = 1'b1;  // sign fill
    end
    return v;
  endfunction

  task automatic issue(input inst_type_t kind, input mem_size_t sz, input logic uns,
                       input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                       input logic [XLEN-1:0] exp_res, input logic exp_err);
    @(posedge clk);
    valid_pre_i <= 1'b1;
    inst_type_i <= kind;
    size_i      <= sz;
    unsigned_i  <= uns;
    op_a_i      <= a;
    op_b_i      <= b;
    @(negedge clk);
    while (!ready_pre_o) @(negedge clk);
    exp_res_q.push_back(exp_res);  // accepted on the next rising edge
    exp_err_q.push_back(exp_err);
    @(posedge clk);
    valid_pre_i <= 1'b0;
  endtask

  task automatic mem_store(input logic [ADDR_W-1:0] a, input logic [XLEN-1:0] d,
                           input mem_size_t sz);
    if (in_range(a)) ref_store(a, d, sz);
    issue(INST_STORE, sz, 1'b0, {32'h0, a}, d, '0, !in_range(a));
  endtask

  task automatic mem_load(input logic [ADDR_W-1:0] a, input mem_size_t sz, input logic uns);
    issue(INST_LOAD, sz, uns, {32'h0, a}, rand_bits(64),
          in_range(a) ? ref_load(a, sz, uns) : '0, !in_range(a));
  endtask

  task automatic finish_test(inout int xfer_mark, inout int fail_mark);
    @(negedge clk);
    while (!ready_pre_o) @(negedge clk);  // back to idle, last result gone
    @(negedge clk);
    $display("%s: %0d results, %0d errors", cur_test, xfer_cnt - xfer_mark,
             fail_cnt - fail_mark);
    xfer_mark = xfer_cnt;
    fail_mark = fail_cnt;
  endtask

  // ----------------------------------------------------------
  // expected-result bookkeeping
  // ----------------------------------------------------------
  always @(negedge clk) begin
    head_valid = exp_res_q.size() != 0;
    if (head_valid) begin
      head_res = exp_res_q[0];
      head_err = exp_err_q[0];
    end
    xfer_next = valid_post_o && ready_post_i;
  end

  always @(posedge clk) begin
    if (xfer_next) begin
      xfer_cnt++;
      if (exp_res_q.size() != 0) begin
        void'(exp_res_q.pop_front());
        void'(exp_err_q.pop_front());
      end
    end
  end

  // random low stretches on the write-back ready
  initial begin
    ready_post_i = 1'b1;
    forever begin
      @(posedge clk);
      if (!bp_en) begin
        ready_post_i <= 1'b1;
      end else if (stretch == 2'd0) begin
        ready_post_i <= rand_bits(1) != '0;
        stretch      <= 2'(rand_bits(2));
      end else begin
        stretch <= stretch - 2'd1;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == LIMIT) begin
      $display("timeout after %0d cycles in %s, a result never came back", cycles, cur_test);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  a_result: assert property (@(posedge clk) disable iff (!rst)
    valid_post_o && ready_post_i |-> head_valid && result_o == head_res && err_o == head_err)
    else begin
      fail_cnt++;
      if (!head_valid) begin
        $display("%s: result delivered with no instruction outstanding", cur_test);
      end else begin
        $display("Mismatch in %s: expected %h err %b, actual %h err %b", cur_test,
                 head_res, head_err, $sampled(result_o), $sampled(err_o));
      end
    end

  a_hold: assert property (@(posedge clk) disable iff (!rst)
    valid_post_o && !ready_post_i |=> valid_post_o && $stable(result_o) && $stable(err_o))
    else begin
      fail_cnt++;
      $display("%s: result dropped or changed while write-back stalled", cur_test);
    end

  a_busy: assert property (@(posedge clk) disable iff (!rst)
    valid_post_o |-> !ready_pre_o)
    else begin
      fail_cnt++;
      $display("%s: ready_pre_o high while a result is waiting", cur_test);
    end

  a_alu_lat: assert property (@(posedge clk) disable iff (!rst)
    valid_pre_i && ready_pre_o && inst_type_i == INST_ALU |=> valid_post_o)
    else begin
      fail_cnt++;
      $display("%s: alu result not valid one cycle after issue", cur_test);
    end

  a_mem_lat: assert property (@(posedge clk) disable iff (!rst)
    valid_pre_i && ready_pre_o && inst_type_i != INST_ALU |-> ##2 valid_post_o)
    else begin
      fail_cnt++;
      $display("%s: memory result not valid two cycles after issue", cur_test);
    end

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    logic [ADDR_W-1:0] a;
    logic [XLEN-1:0]   d;
    logic [XLEN-1:0]   x;
    mem_size_t         sz;
    int                k;
    int                xfer_mark;
    int                fail_mark;
    rst         = 1'b0;
    valid_pre_i = 1'b0;
    inst_type_i = INST_ALU;
    size_i      = SIZE_D;
    unsigned_i  = 1'b0;
    op_a_i      = '0;
    op_b_i      = '0;
    bp_en       = 1'b0;
    stretch     = 2'd0;
    lfsr        = 32'd85749;
    xfer_mark   = 0;
    fail_mark   = 0;
    cur_test    = "reset";
    repeat (5) @(posedge clk);
    rst <= 1'b1;

    cur_test = "alu_add";
    for (int i = 0; i < N_ALU; i++) begin
      x = rand_bits(64);
      d = rand_bits(64);
      issue(INST_ALU, SIZE_D, 1'b0, x, d, x + d, 1'b0);
    end
    finish_test(xfer_mark, fail_mark);

    cur_test = "store_load_dword";
    for (int i = 0; i < N_PAIRS; i++) begin
      a = ADDR_W'(rand_bits(IDX_W)) << 3;
      mem_store(a, rand_bits(64), SIZE_D);
      mem_load(a, SIZE_D, rand_bits(1) != '0);
    end
    finish_test(xfer_mark, fail_mark);

    cur_test = "sub_word";
    a = ADDR_W'(rand_bits(IDX_W)) << 3;
    mem_store(a, 64'h0123_4567_89ab_cdef, SIZE_D);
    mem_store(a + 1, rand_bits(64), SIZE_B);
    mem_store(a + 2, rand_bits(64), SIZE_H);
    mem_store(a + 4, rand_bits(64), SIZE_W);
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 8; off += (1 << s)) begin
        mem_load(a + off, mem_size_t'(s), 1'b0);
        mem_load(a + off, mem_size_t'(s), 1'b1);
      end
    end
    finish_test(xfer_mark, fail_mark);

    cur_test = "out_of_range";
    a = ADDR_W'(rand_bits(IDX_W)) << 3;
    d = rand_bits(64);
    mem_store(a, d, SIZE_D);
    mem_store(a | 32'h0010_0000, ~d, SIZE_D);  // same low index bits as a
    mem_load(a | 32'h0010_0000, SIZE_D, 1'b0);
    mem_load(a | 32'h8000_0000, SIZE_W, 1'b0);
    mem_load(a, SIZE_D, 1'b0);
    finish_test(xfer_mark, fail_mark);

    // mixed traffic on words 0..7 with a stalling write-back
    cur_test = "back_pressure";
    for (int i = 0; i < 8; i++) begin
      mem_store(ADDR_W'(i * 8), rand_bits(64), SIZE_D);
    end
    bp_en = 1'b1;
    for (int i = 0; i < N_MIXED; i++) begin
      k  = int'(rand_bits(2));
      sz = mem_size_t'(2'(rand_bits(2)));
      a  = ADDR_W'(rand_bits(6));
      a  = a & ~ADDR_W'((1 << sz) - 1);  // size aligned
      if (k == 1) begin
        mem_load(a, sz, rand_bits(1) != '0);
      end else if (k == 2) begin
        mem_store(a, rand_bits(64), sz);
      end else begin
        x = rand_bits(64);
        d = rand_bits(64);
        issue(INST_ALU, SIZE_D, 1'b0, x, d, x + d, 1'b0);
      end
    end
    finish_test(xfer_mark, fail_mark);
    bp_en = 1'b0;

    $display("summary: 5 tests, %0d results, %0d failures, %0d left in queue",
             xfer_cnt, fail_cnt, exp_res_q.size());
    if (fail_cnt == 0 && exp_res_q.size() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
verilog/exu_pkg.sv
verilog/exu_fsm.sv
verilog/exu_lsu.sv
verilog/axi_dmem.sv
verilog/exu_top.sv
tb/tb_exu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exu_top -f flist.f \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

# an aborted run counts as a failure
./obj_dir/Vtb_exu_top > sim.log 2>&1 || echo "TEST RESULT: FAIL" >> sim.log
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
